//--- test/joypad_input.txt
# D dl_cycles busy_cycles release_edges | F fail_cycles | R reset then hold check
# J tap p1 p2 p3 p4 (hex) port1_report port2_report (24-bit hex) | C port(0=strobe) joy1 joy2
D 5 0 255
D 3 20 275
# multitap off, primary then ones
J 0 a5 3c 00 00 ffffa5 ffff3c
J 0 ff 00 12 34 ffffff ffff00
# multitap on, primary then secondary then signature
J 1 81 42 c3 18 08c381 041842
J 1 0f f0 55 aa 08550f 04aaf0
J 1 00 00 00 00 080000 040000
J 1 03 02 00 00 080003 040002
# one port at a time
C 0 1 0
C 2 1 1
C 2 1 0
C 1 1 0
C 1 0 0
C 0 1 0
C 1 1 0
C 1 0 0
F 4
J 0 5a c3 00 00 ffff5a ffffc3
D 1 7 262
J 1 11 22 33 44 083311 044422
F 1
R
D 2 0 255
J 1 11 22 33 44 083311 044422
J 0 01 80 00 00 ffff01 ffff80

//--- verilog.f
+incdir+rtl
rtl/nes_input_pkg.sv
rtl/joypad_port.sv
rtl/reset_sequencer.sv
rtl/nes_input_top.sv
test/nes_input_checker.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench, a failing run exits non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_top \
  -Mdir build \
  -f verilog.f

./build/Vtb_top

//--- test/tb_top.sv
`timescale 1ns/1ps
`include "nes_input_defs.svh"
`default_nettype none

module tb_top;

  import nes_input_pkg::*;

  localparam int RESET_CYCLES    = 10;
  localparam int HOLD_CYCLES     = 50;
  localparam int BUSY_START      = 10;
  localparam int RELEASE_TIMEOUT = 1000;

  logic         clk_ppu_21_47;
  logic         reset_nes;
  logic         joy_strobe;
  logic [1:0]   joy_clock;
  nes_buttons_t p1_buttons;
  nes_buttons_t p2_buttons;
  nes_buttons_t p3_buttons;
  nes_buttons_t p4_buttons;
  logic         multitap_enabled;
  logic         downloading;
  logic         loader_busy;
  logic         loader_fail;
  logic         joy1_data;
  logic         joy2_data;
  logic         core_reset;
  logic         loader_reset;

  // data file parsing
  int         fd;
  int         code;
  logic       done;
  logic [7:0] cmd;
  int         arg_a;
  int         arg_b;
  int         arg_c;
  logic [7:0] pad1;
  logic [7:0] pad2;
  logic [7:0] pad3;
  logic [7:0] pad4;
  logic [`JOY_REPORT_BITS-1:0] exp1;
  logic [`JOY_REPORT_BITS-1:0] exp2;
  logic       exp_bit1;
  logic       exp_bit2;

  // serial words collected from both ports, first bit at bit 0
  logic [`JOY_REPORT_BITS-1:0] got1;
  logic [`JOY_REPORT_BITS-1:0] got2;

  nes_input_top i_dut (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .joy_strobe       (joy_strobe),
    .joy_clock        (joy_clock),
    .joy1_data        (joy1_data),
    .joy2_data        (joy2_data),
    .p1_buttons       (p1_buttons),
    .p2_buttons       (p2_buttons),
    .p3_buttons       (p3_buttons),
    .p4_buttons       (p4_buttons),
    .multitap_enabled (multitap_enabled),
    .downloading      (downloading),
    .loader_busy      (loader_busy),
    .loader_fail      (loader_fail),
    .core_reset       (core_reset),
    .loader_reset     (loader_reset)
  );

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #2 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  // inputs move 1 ns after the rising edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk_ppu_21_47);
    #1;
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t: %s expected %0b got %0b", $time, what, exp, got));
    end
  endtask

  task automatic check_report(input string what, input joy_report_t got,
                              input joy_report_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t: %s report expected %06h got %06h",
                         $time, what, exp, got));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("[ERROR] %0t: %s expected %0d got %0d", $time, what, exp, got));
    end
  endtask

  task automatic apply_reset();
    reset_nes   = 1'b1;
    downloading = 1'b0;
    loader_busy = 1'b0;
    loader_fail = 1'b0;
    joy_strobe  = 1'b0;
    joy_clock   = 2'b00;
    repeat (RESET_CYCLES) next_cycle();
    reset_nes = 1'b0;
  endtask

  // core waits for a download, ports stay clear even with strobe and clocks
  task automatic check_hold(input int cycles);
    p1_buttons       = 8'hff;
    p2_buttons       = 8'hff;
    p3_buttons       = 8'hff;
    p4_buttons       = 8'hff;
    multitap_enabled = 1'b1;
    joy_strobe       = 1'b1;
    repeat (cycles) begin
      next_cycle();
      check_bit("core_reset before download", core_reset, 1'b1);
      check_bit("joy1_data before download", joy1_data, 1'b0);
      check_bit("joy2_data before download", joy2_data, 1'b0);
      joy_clock = ~joy_clock;
    end
    joy_strobe       = 1'b0;
    joy_clock        = 2'b00;
    multitap_enabled = 1'b0;
    p1_buttons       = '0;
    p2_buttons       = '0;
    p3_buttons       = '0;
    p4_buttons       = '0;
  endtask

  // busy goes high after BUSY_START counting edges and stays for n_busy
  task automatic run_download(input int n_dl, input int n_busy, input int exp_count);
    int   count;
    logic released;
    count    = 0;
    released = 1'b0;
    downloading = 1'b1;
    repeat (n_dl) begin
      next_cycle();
      check_bit("core_reset while downloading", core_reset, 1'b1);
    end
    downloading = 1'b0;
    while (!released && count < RELEASE_TIMEOUT) begin
      next_cycle();
      count++;
      check_bit("loader_reset during hold", loader_reset, 1'b0);
      if (core_reset === 1'b0) begin
        released = 1'b1;
      end
      loader_busy = !released && count >= BUSY_START && count < BUSY_START + n_busy;
    end
    loader_busy = 1'b0;
    if (!released) begin
      fail_run("timeout: core_reset never released after the download");
    end else begin
      check_count("release edges", count, exp_count);
      next_cycle();
      check_bit("loader_reset after release", loader_reset, 1'b1);
    end
  endtask

  // 24 falling clocks on both ports
  task automatic shift_out();
    got1 = '0;
    got2 = '0;
    repeat (`JOY_REPORT_BITS) begin
      // first bit ends up at bit 0
      got1 = {joy1_data, got1[`JOY_REPORT_BITS-1:1]};
      got2 = {joy2_data, got2[`JOY_REPORT_BITS-1:1]};
      joy_clock = 2'b11;
      next_cycle();
      joy_clock = 2'b00;
      next_cycle();
    end
  endtask

  // strobe once, then read the full word from both ports
  task automatic read_pads(input logic tap, input joy_report_t e1, input joy_report_t e2);
    multitap_enabled = tap;
    p1_buttons = pad1;
    p2_buttons = pad2;
    p3_buttons = pad3;
    p4_buttons = pad4;
    joy_strobe = 1'b1;
    next_cycle();
    joy_strobe = 1'b0;
    shift_out();
    check_report("port 1", got1, e1);
    check_report("port 2", got2, e2);
    check_bit("joy1_data past report", joy1_data, 1'b0);
    check_bit("joy2_data past report", joy2_data, 1'b0);
  endtask

  // index 0 strobes, 1 or 2 gives one falling clock on that port
  task automatic step_port(input int idx, input logic e1, input logic e2);
    if (idx == 0) begin
      joy_strobe = 1'b1;
      next_cycle();
      joy_strobe = 1'b0;
    end else if (idx == 1 || idx == 2) begin
      joy_clock = (idx == 1) ? 2'b01 : 2'b10;
      next_cycle();
      joy_clock = 2'b00;
      next_cycle();
    end else begin
      fail_run("bad port index in C line of data file");
    end
    check_bit("joy1_data after step", joy1_data, e1);
    check_bit("joy2_data after step", joy2_data, e2);
  endtask

  // a latched report has a nonzero top byte, so the fail reset must clear it
  task automatic pulse_fail(input int cycles);
    joy_strobe = 1'b1;
    next_cycle();
    joy_strobe  = 1'b0;
    loader_fail = 1'b1;
    repeat (cycles) begin
      next_cycle();
      check_bit("core_reset during loader_fail", core_reset, 1'b1);
    end
    loader_fail = 1'b0;
    next_cycle();
    check_bit("core_reset after loader_fail", core_reset, 1'b0);
    shift_out();
    check_report("port 1 after loader_fail", got1, '0);
    check_report("port 2 after loader_fail", got2, '0);
  endtask

  task automatic skip_line();
    int ch;
    ch = 0;
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  task automatic run_command(input logic [7:0] op);
    case (op)
      "#": skip_line();
      "D": begin
        code = $fscanf(fd, "%d %d %d", arg_a, arg_b, arg_c);
        if (code != 3) fail_run("malformed D line in data file");
        else run_download(arg_a, arg_b, arg_c);
      end
      "J": begin
        code = $fscanf(fd, "%d %h %h %h %h %h %h", arg_a, pad1, pad2, pad3, pad4, exp1, exp2);
        if (code != 7) fail_run("malformed J line in data file");
        else read_pads(arg_a != 0, exp1, exp2);
      end
      "C": begin
        code = $fscanf(fd, "%d %b %b", arg_a, exp_bit1, exp_bit2);
        if (code != 3) fail_run("malformed C line in data file");
        else step_port(arg_a, exp_bit1, exp_bit2);
      end
      "F": begin
        code = $fscanf(fd, "%d", arg_a);
        if (code != 1) fail_run("malformed F line in data file");
        else pulse_fail(arg_a);
      end
      "R": begin
        apply_reset();
        check_hold(HOLD_CYCLES);
      end
      default: fail_run("unknown command in data file");
    endcase
  endtask

  initial begin
    reset_nes        = 1'b1;
    joy_strobe       = 1'b0;
    joy_clock        = 2'b00;
    p1_buttons       = '0;
    p2_buttons       = '0;
    p3_buttons       = '0;
    p4_buttons       = '0;
    multitap_enabled = 1'b0;
    downloading      = 1'b0;
    loader_busy      = 1'b0;
    loader_fail      = 1'b0;
    done             = 1'b0;
    apply_reset();
    check_hold(HOLD_CYCLES);
    fd = $fopen("test/joypad_input.txt", "r");
    if (fd == 0) begin
      fail_run("could not open test/joypad_input.txt");
    end else begin
      while (!done) begin
        code = $fscanf(fd, " %c", cmd);
        if (code != 1) done = 1'b1;
        else run_command(cmd);
      end
      $fclose(fd);
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- test/nes_input_checker.sv
`timescale 1ns/1ps
`default_nettype none

module nes_input_checker (
  input wire logic clk_ppu_21_47,
  input wire logic reset_nes,
  input wire logic downloading,
  input wire logic core_reset,
  input wire logic loader_reset,
  input wire logic joy1_data,
  input wire logic joy2_data
);

  // ports sit in core reset, so their serial bits drop on the next edge
  a_reset_clears_data: assert property (
    @(posedge clk_ppu_21_47) core_reset |=> (!joy1_data && !joy2_data)
  ) else $error("core_reset was not followed by low serial data");

  // counter reload keeps the core held
  a_download_holds_core: assert property (
    @(posedge clk_ppu_21_47) downloading |=> core_reset
  ) else $error("downloading was not followed by core_reset");

  a_download_resets_loader: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    $rose(downloading) |=> loader_reset
  ) else $error("download start was not followed by loader_reset");

endmodule

bind nes_input_top nes_input_checker i_checker (
  .clk_ppu_21_47 (clk_ppu_21_47),
  .reset_nes     (reset_nes),
  .downloading   (downloading),
  .core_reset    (core_reset),
  .loader_reset  (loader_reset),
  .joy1_data     (joy1_data),
  .joy2_data     (joy2_data)
);

`default_nettype wire

//--- rtl/nes_input_top.sv
`timescale 1ns/1ps
`include "nes_input_defs.svh"
`default_nettype none

module nes_input_top (
  input  wire logic                        clk_ppu_21_47,
  input  wire logic                        reset_nes,

  // console side of the controller ports
  input  wire logic                        joy_strobe,
  input  wire logic [1:0]                  joy_clock,
  output logic                             joy1_data,
  output logic                             joy2_data,

  // pads, high means pressed
  input  wire nes_input_pkg::nes_buttons_t p1_buttons,
  input  wire nes_input_pkg::nes_buttons_t p2_buttons,
  input  wire nes_input_pkg::nes_buttons_t p3_buttons,
  input  wire nes_input_pkg::nes_buttons_t p4_buttons,
  input  wire logic                        multitap_enabled,

  // loader status and resets
  input  wire logic                        downloading,
  input  wire logic                        loader_busy,
  input  wire logic                        loader_fail,
  output logic                             core_reset,
  output logic                             loader_reset
);

  // core reset also clears both ports
  reset_sequencer i_reset_sequencer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .loader_busy   (loader_busy),
    .loader_fail   (loader_fail),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset)
  );

  // port 1 carries players 1 and 3
  joypad_port #(
    .signature (`JOY_SIG_PORT1)
  ) port1 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (core_reset),
    .strobe           (joy_strobe),
    .serial_clock     (joy_clock[0]),
    .primary          (p1_buttons),
    .secondary        (p3_buttons),
    .multitap_enabled (multitap_enabled),
    .serial_data      (joy1_data)
  );

  // port 2 carries players 2 and 4
  joypad_port #(
    .signature (`JOY_SIG_PORT2)
  ) port2 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (core_reset),
    .strobe           (joy_strobe),
    .serial_clock     (joy_clock[1]),
    .primary          (p2_buttons),
    .secondary        (p4_buttons),
    .multitap_enabled (multitap_enabled),
    .serial_data      (joy2_data)
  );

endmodule

`default_nettype wire

//--- rtl/reset_sequencer.sv
`timescale 1ns/1ps
`include "nes_input_defs.svh"
`default_nettype none

module reset_sequencer (
  input  wire logic clk_ppu_21_47,
  input  wire logic reset_nes,
  input  wire logic downloading,
  input  wire logic loader_busy,
  input  wire logic loader_fail,
  output logic      core_reset,
  output logic      loader_reset
);

  import nes_input_pkg::*;

  // set by the first download, core stays in reset until then
  logic started;

  // post-download hold, counts down while the loader is idle
  logic [`DOWNLOAD_CNT_BITS-1:0] hold_cnt;
  logic                          hold_active;

  // downloading from the previous edge
  logic downloading_d;
  logic download_rise;

  assign hold_active   = hold_cnt != '0;
  assign download_rise = downloading && !downloading_d;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      started       <= 1'b0;
      hold_cnt      <= '0;
      downloading_d <= 1'b0;
    end else begin
      downloading_d <= downloading;
      if (downloading) begin
        started  <= 1'b1;
        hold_cnt <= `DOWNLOAD_CNT_BITS'(`DOWNLOAD_RESET_CYCLES);
      end else if (!loader_busy && hold_active) begin
        // busy loader freezes the count
        hold_cnt <= hold_cnt - 1'b1;
      end
    end
  end

  // loader reset once the hold has run out, or as a download starts
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      // counter is zero during reset
      loader_reset <= 1'b1;
    end else begin
      loader_reset <= !hold_active || download_rise;
    end
  end

  // all core reset sources merged, no register on this path
  assign core_reset = !started || hold_active || loader_fail || reset_nes;

endmodule

`default_nettype wire

//--- rtl/joypad_port.sv
`timescale 1ns/1ps
`include "nes_input_defs.svh"
`default_nettype none

module joypad_port #(
  parameter nes_input_pkg::nes_buttons_t signature = `JOY_SIG_PORT1
) (
  input  wire logic                        clk_ppu_21_47,
  input  wire logic                        reset_nes,
  input  wire logic                        strobe,
  input  wire logic                        serial_clock,
  input  wire nes_input_pkg::nes_buttons_t primary,
  input  wire nes_input_pkg::nes_buttons_t secondary,
  input  wire logic                        multitap_enabled,
  output logic                             serial_data
);

  import nes_input_pkg::*;

  // word that a strobe would latch right now
  joy_report_t strobe_report;

  // shift register, bit 0 is on the wire
  joy_report_t report;

  // clock level seen on the previous edge
  logic last_clock;
  logic clock_fall;

  // build the latch value from the pads
  always_comb begin
    strobe_report.primary = primary;
    if (multitap_enabled) begin
      strobe_report.secondary = secondary;
      strobe_report.signature = signature;
    end else begin
      // no tap, console reads ones past the first pad
      {strobe_report.signature, strobe_report.secondary} = `JOY_NO_TAP_FILL;
    end
  end

  // falling edge of the console's serial clock
  assign clock_fall = !serial_clock && last_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      last_clock <= 1'b0;
    end else begin
      last_clock <= serial_clock;
    end
  end

  // latch on strobe, shift on clock fall
  // a shift on the same edge as a strobe takes priority
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      report <= '0;
    end else if (clock_fall) begin
      // zeros fill in from the top once the word is used up
      report <= {1'b0, report[`JOY_REPORT_BITS-1:1]};
    end else if (strobe) begin
      report <= strobe_report;
    end
  end

  // bit 0 goes straight out
  assign serial_data = report[0];

endmodule

`default_nettype wire

//--- rtl/nes_input_pkg.sv
`default_nettype none

package nes_input_pkg;

  // one player's pad, bit 0 is a and bit 7 is right
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_buttons_t;

  // word shifted out of a port, lsb first
  // primary pad goes out first, then the tap player, then the signature
  typedef struct packed {
    // multitap id byte, or fill when the tap is off
    logic [7:0]   signature;
    // second player on this port
    nes_buttons_t secondary;
    // player plugged straight into the port
    nes_buttons_t primary;
  } joy_report_t;

endpackage

`default_nettype wire

//--- rtl/nes_input_defs.svh
`default_nettype none

`ifndef NES_INPUT_DEFS_SVH
`define NES_INPUT_DEFS_SVH

// bits in one controller read
`define JOY_REPORT_BITS 24

// upper report bits with no multitap attached
`define JOY_NO_TAP_FILL 16'hFFFF

// multitap signature bytes, one per port
`define JOY_SIG_PORT1 8'h08
`define JOY_SIG_PORT2 8'h04

// core held in reset this many loader-idle cycles after a download
`define DOWNLOAD_RESET_CYCLES 255
`define DOWNLOAD_CNT_BITS 8

`endif

`default_nettype wire
